/* src/espm_pkg.sv */
// ESPM receive path package: address spaces, register offsets, buffer map, structs, address union
package espm_pkg;

    // --------------------------------------------------------------------------
    // host address spaces and offsets
    // --------------------------------------------------------------------------
    localparam logic [3:0] ADDR_MAIN           = 4'h0;
    localparam logic [3:0] ADDR_BOARD_SPECIFIC = 4'hB;
    localparam logic [3:0] ADDR_ESPM           = 4'hC;

    localparam logic [3:0] OFF_ADC_DATA = 4'd0;  // pot in upper half
    localparam logic [3:0] OFF_ENC_LOAD = 4'd4;
    localparam logic [3:0] OFF_ENC_DATA = 4'd5;

    localparam logic [11:0] BS_CRC_ERR    = 12'h000;
    localparam logic [11:0] BS_CRC_GOOD   = 12'h001;
    localparam logic [11:0] BS_ESII       = 12'h010;
    localparam logic [11:0] BS_INST_MODEL = 12'h012;
    localparam logic [11:0] BS_INST_ID    = 12'h013;
    localparam logic [11:0] BS_SWITCH     = 12'h021;
    localparam logic [11:0] BS_BUILD      = 12'hFFF;

    localparam logic [31:0] BUILD_NUMBER = 32'd2;
    localparam logic [31:0] READ_FILL    = 32'h0000CCCC;
    localparam logic [15:0] POT_FILL     = 16'hCCCC;

    // --------------------------------------------------------------------------
    // frame buffer map
    // --------------------------------------------------------------------------
    localparam int          BUF_WORDS    = 64;
    localparam int          NUM_ENC      = 7;
    localparam logic [23:0] ENC_MIDRANGE = 24'h800000;

    localparam logic [2:0] ROW_POS = 3'd1;  // words 9..15
    localparam logic [2:0] ROW_POT = 3'd2;  // words 17..23

    localparam logic [5:0] W_SWITCH        = 6'h30;
    localparam logic [5:0] W_ESII          = 6'h31;
    localparam logic [5:0] W_INST_MODEL    = 6'h32;
    localparam logic [5:0] W_INST_ID       = 6'h33;
    localparam logic [5:0] W_PRELOAD_VALID = 6'h34;

    // host address, two decodings of the same word
    typedef struct packed {
        logic [3:0] space;
        logic [3:0] unused;
        logic [3:0] chan;
        logic [3:0] offset;
    } main_addr_t;

    typedef struct packed {
        logic [3:0]  space;
        logic [11:0] offset;
    } board_addr_t;

    typedef union packed {
        main_addr_t  main;
        board_addr_t board;
    } reg_addr_u;

    typedef struct packed {
        logic        valid;
        logic [5:0]  sel;
        logic [31:0] data;
        logic        eof;
        logic        crc_good;
    } rx_beat_t;

    typedef struct packed {
        logic        wen;
        reg_addr_u   waddr;
        logic [31:0] wdata;
    } reg_wr_t;

    typedef struct packed {
        logic        valid;
        logic [5:0]  addr;
        logic [31:0] data;
    } commit_beat_t;

    typedef struct packed {
        logic [1:NUM_ENC][23:0] pos;
        logic [1:NUM_ENC][11:0] pot;
        logic [31:0]            switch_word;
        logic [31:0]            esii_word;
        logic [31:0]            inst_model;
        logic [31:0]            inst_id;
        logic                   preload_valid;
    } espm_fields_t;

    typedef struct packed {
        logic [1:NUM_ENC][23:0] preload;
        logic [1:NUM_ENC][23:0] position;
        logic [1:NUM_ENC]       overflow;
    } enc_state_t;

endpackage

/* src/frame_store.sv */
// staging buffer, commit copy sequencer and committed buffer with host read port
`timescale 1ns/1ns

module frame_store (
    input  logic                   sysclk,
    input  logic                   rst_n_i,
    input  espm_pkg::rx_beat_t     rx_beat_i,
    input  logic [5:0]             rd_addr_i,
    output espm_pkg::commit_beat_t commit_o,
    output logic [31:0]            rd_data_o
);

    typedef enum logic {
        ST_IDLE,
        ST_COPY
    } copy_state_e;

    logic [31:0] stage_mem  [espm_pkg::BUF_WORDS];
    logic [31:0] commit_mem [espm_pkg::BUF_WORDS];

    copy_state_e state;
    logic [5:0]  rd_ptr;     // staging read address
    logic        copy_we;
    logic [5:0]  copy_addr;
    logic [31:0] copy_data;

    // --------------------------------------------------------------------------
    // staging buffer, written straight from the link
    // --------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rx_beat_i.valid) begin
            stage_mem[rx_beat_i.sel] <= rx_beat_i.data;
        end
    end

    // --------------------------------------------------------------------------
    // copy sequencer
    // --------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= ST_IDLE;
            rd_ptr  <= '0;
            copy_we <= 1'b0;
        end else begin
            copy_we <= (state == ST_COPY);  // read data lands one cycle later
            case (state)
                ST_IDLE: begin
                    if (rx_beat_i.crc_good) begin
                        state <= ST_COPY;
                    end
                end
                ST_COPY: begin
                    rd_ptr <= rd_ptr + 6'd1;  // wraps back to 0 after last word
                    if (rd_ptr == 6'(espm_pkg::BUF_WORDS - 1)) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // staging read stage
    always_ff @(posedge sysclk) begin
        copy_data <= stage_mem[rd_ptr];
        copy_addr <= rd_ptr;
    end

    // --------------------------------------------------------------------------
    // committed buffer and host port
    // --------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (copy_we) begin
            commit_mem[copy_addr] <= copy_data;
        end
        rd_data_o <= commit_mem[rd_addr_i];  // one cycle latency
    end

    // every copied word also goes to the decoder
    assign commit_o.valid = copy_we;
    assign commit_o.addr  = copy_addr;
    assign commit_o.data  = copy_data;

endmodule

/* src/field_decode.sv */
// decoder latching position, pot, status and preload-valid fields from commit beats
`timescale 1ns/1ns

module field_decode (
    input  logic                   sysclk,
    input  logic                   rst_n_i,
    input  espm_pkg::commit_beat_t commit_i,
    output espm_pkg::espm_fields_t fields_o
);

    logic [2:0] row;
    logic [2:0] col;

    assign row = commit_i.addr[5:3];
    assign col = commit_i.addr[2:0];

    // --------------------------------------------------------------------------
    // field latches
    // --------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fields_o <= '0;
        end else if (commit_i.valid) begin
            // column 0 of each row carries no channel
            if (col != 3'd0) begin
                if (row == espm_pkg::ROW_POS) begin
                    fields_o.pos[col] <= commit_i.data[23:0];
                end
                if (row == espm_pkg::ROW_POT) begin
                    fields_o.pot[col] <= commit_i.data[17:6];  // 12-bit pot sample
                end
            end

            case (commit_i.addr)
                espm_pkg::W_SWITCH: begin
                    fields_o.switch_word <= commit_i.data;
                end
                espm_pkg::W_ESII: begin
                    fields_o.esii_word <= commit_i.data;  // bit1 esii good, bit0 ecm
                end
                espm_pkg::W_INST_MODEL: begin
                    fields_o.inst_model <= commit_i.data;
                end
                espm_pkg::W_INST_ID: begin
                    fields_o.inst_id <= commit_i.data;
                end
                espm_pkg::W_PRELOAD_VALID: begin
                    fields_o.preload_valid <= commit_i.data[0];
                end
                default: begin
                    // position and pot rows handled above
                end
            endcase
        end
    end

endmodule

/* src/encoder_preload.sv */
// encoder preload registers, offsets, adjusted positions and overflow flags
`timescale 1ns/1ns

module encoder_preload (
    input  logic                   sysclk,
    input  logic                   rst_n_i,
    input  espm_pkg::reg_wr_t      reg_wr_i,
    input  espm_pkg::espm_fields_t fields_i,
    output espm_pkg::enc_state_t   enc_o
);

    logic [1:espm_pkg::NUM_ENC][23:0] preload_q;
    logic [1:espm_pkg::NUM_ENC][23:0] offset_q;
    logic [1:espm_pkg::NUM_ENC][23:0] pos_adj;
    logic [1:espm_pkg::NUM_ENC]       ovf_q;

    logic       ld_hit;
    logic [3:0] ld_chan;

    // --------------------------------------------------------------------------
    // preload write decode
    // --------------------------------------------------------------------------
    assign ld_chan = reg_wr_i.waddr.main.chan;
    assign ld_hit  = reg_wr_i.wen
                  && (reg_wr_i.waddr.main.space == espm_pkg::ADDR_MAIN)
                  && (reg_wr_i.waddr.main.offset == espm_pkg::OFF_ENC_LOAD)
                  && (ld_chan != 4'd0) && !ld_chan[3];  // channels 1..7 only

    // adjusted position, wraps mod 2^24
    always_comb begin
        for (int c = 1; c <= espm_pkg::NUM_ENC; c++) begin
            pos_adj[c] = fields_i.pos[c] + offset_q[c];
        end
    end

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int c = 1; c <= espm_pkg::NUM_ENC; c++) begin
                preload_q[c] <= espm_pkg::ENC_MIDRANGE;
                offset_q[c]  <= '0;
            end
            ovf_q <= '0;
        end else if (ld_hit) begin
            for (int c = 1; c <= espm_pkg::NUM_ENC; c++) begin
                if (ld_chan == 4'(c)) begin
                    preload_q[c] <= reg_wr_i.wdata[23:0];
                    offset_q[c]  <= reg_wr_i.wdata[23:0] - fields_i.pos[c];
                    ovf_q[c]     <= 1'b0;
                end
            end
        end else begin
            // sticky until the next preload of that channel
            for (int c = 1; c <= espm_pkg::NUM_ENC; c++) begin
                if ((pos_adj[c][23:12] == 12'h000) || (pos_adj[c][23:12] == 12'hFFF)) begin
                    ovf_q[c] <= 1'b1;
                end
            end
        end
    end

    assign enc_o.preload  = preload_q;
    assign enc_o.position = pos_adj;
    assign enc_o.overflow = ovf_q;

endmodule

/* src/link_monitor.sv */
// good/error frame counters and communication watchdog
`timescale 1ns/1ns

module link_monitor #(
    parameter int WDOG_CYCLES = 491520
) (
    input  logic               sysclk,
    input  logic               rst_n_i,
    input  espm_pkg::rx_beat_t rx_beat_i,
    output logic [31:0]        good_count_o,
    output logic [31:0]        err_count_o,
    output logic               comm_good_o
);

    localparam int WIN_W = $clog2(WDOG_CYCLES);

    logic [WIN_W-1:0] win_cnt;
    logic [9:0]       good_prev;  // good count at last window end

    // --------------------------------------------------------------------------
    // frame counters
    // --------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            good_count_o <= '0;
            err_count_o  <= '0;
        end else begin
            if (rx_beat_i.crc_good) begin
                good_count_o <= good_count_o + 32'd1;
            end
            if (rx_beat_i.eof && !rx_beat_i.crc_good) begin
                err_count_o <= err_count_o + 32'd1;  // eof with bad crc
            end
        end
    end

    // watchdog window
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            win_cnt     <= '0;
            good_prev   <= '0;
            comm_good_o <= 1'b0;
        end else if (win_cnt == WIN_W'(WDOG_CYCLES - 1)) begin
            win_cnt     <= '0;
            good_prev   <= good_count_o[9:0];
            comm_good_o <= (good_count_o[9:0] != good_prev);  // any progress this window
        end else begin
            win_cnt <= win_cnt + 1'b1;
        end
    end

endmodule

/* src/reg_read_mux.sv */
// registered host readback across main, board-specific and ESPM address spaces
`timescale 1ns/1ns

module reg_read_mux (
    input  logic                   sysclk,
    input  logic                   rst_n_i,
    input  espm_pkg::reg_addr_u    reg_raddr_i,
    input  espm_pkg::espm_fields_t fields_i,
    input  espm_pkg::enc_state_t   enc_i,
    input  logic [31:0]            good_count_i,
    input  logic [31:0]            err_count_i,
    input  logic [31:0]            espm_rd_data_i,
    output logic [31:0]            reg_rdata_o
);

    logic [3:0]  chan;
    logic        chan_ok;     // encoder channels 1..7
    logic [31:0] rdata_next;
    logic [31:0] rdata_q;
    logic        espm_sel_q;  // space tag of the pending read

    assign chan    = reg_raddr_i.main.chan;
    assign chan_ok = (chan != 4'd0) && !chan[3];

    // --------------------------------------------------------------------------
    // read decode
    // --------------------------------------------------------------------------
    always_comb begin
        rdata_next = espm_pkg::READ_FILL;
        if (reg_raddr_i.main.space == espm_pkg::ADDR_MAIN) begin
            case (reg_raddr_i.main.offset)
                espm_pkg::OFF_ADC_DATA: begin
                    // current feedback dropped, lower half stays zero
                    rdata_next = chan_ok ? {4'b0, fields_i.pot[chan[2:0]], 16'h0000}
                                         : {espm_pkg::POT_FILL, 16'h0000};
                end
                espm_pkg::OFF_ENC_LOAD: begin
                    if (chan_ok) rdata_next = {8'b0, enc_i.preload[chan[2:0]]};
                end
                espm_pkg::OFF_ENC_DATA: begin
                    if (chan_ok) begin
                        rdata_next = {7'b0, enc_i.overflow[chan[2:0]],
                                      enc_i.position[chan[2:0]]};
                    end
                end
                default: rdata_next = espm_pkg::READ_FILL;
            endcase
        end else if (reg_raddr_i.board.space == espm_pkg::ADDR_BOARD_SPECIFIC) begin
            case (reg_raddr_i.board.offset)
                espm_pkg::BS_CRC_ERR:    rdata_next = err_count_i;
                espm_pkg::BS_CRC_GOOD:   rdata_next = good_count_i;
                espm_pkg::BS_ESII:       rdata_next = fields_i.esii_word;
                espm_pkg::BS_INST_MODEL: rdata_next = fields_i.inst_model;
                espm_pkg::BS_INST_ID:    rdata_next = fields_i.inst_id;
                espm_pkg::BS_SWITCH:     rdata_next = fields_i.switch_word;
                espm_pkg::BS_BUILD:      rdata_next = espm_pkg::BUILD_NUMBER;
                default:                 rdata_next = espm_pkg::READ_FILL;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        rdata_q <= rdata_next;
    end

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) espm_sel_q <= 1'b0;
        else          espm_sel_q <= (reg_raddr_i.board.space == espm_pkg::ADDR_ESPM);
    end

    // committed buffer word is already registered in frame_store
    assign reg_rdata_o = espm_sel_q ? espm_rd_data_i : rdata_q;

endmodule

/* src/espm_rx_top.sv */
// ESPM receive path top level: frame store, field decode, encoder preload, link monitor, readback
`timescale 1ns/1ns

module espm_rx_top #(
    parameter int WDOG_CYCLES = 491520
) (
    input  logic                sysclk,
    input  logic                rst_n_i,
    input  espm_pkg::rx_beat_t  rx_beat_i,
    input  espm_pkg::reg_wr_t   reg_wr_i,
    input  espm_pkg::reg_addr_u reg_raddr_i,
    output logic [31:0]         reg_rdata_o,
    output logic                comm_good_o,
    output logic                esii_good_o,
    output logic                is_ecm_o,
    output logic                preload_good_o
);

    espm_pkg::commit_beat_t commit;
    espm_pkg::espm_fields_t fields;
    espm_pkg::enc_state_t   enc;
    logic [31:0]            good_count;
    logic [31:0]            err_count;
    logic [31:0]            espm_rd_data;

    // --------------------------------------------------------------------------
    // receive pipeline
    // --------------------------------------------------------------------------
    frame_store frame_store_inst (
        .sysclk    (sysclk),
        .rst_n_i   (rst_n_i),
        .rx_beat_i (rx_beat_i),
        .rd_addr_i (reg_raddr_i[5:0]),  // word index inside ESPM space
        .commit_o  (commit),
        .rd_data_o (espm_rd_data)
    );

    field_decode field_decode_inst (
        .sysclk   (sysclk),
        .rst_n_i  (rst_n_i),
        .commit_i (commit),
        .fields_o (fields)
    );

    encoder_preload encoder_preload_inst (
        .sysclk   (sysclk),
        .rst_n_i  (rst_n_i),
        .reg_wr_i (reg_wr_i),
        .fields_i (fields),
        .enc_o    (enc)
    );

    link_monitor #(
        .WDOG_CYCLES (WDOG_CYCLES)
    ) link_monitor_inst (
        .sysclk       (sysclk),
        .rst_n_i      (rst_n_i),
        .rx_beat_i    (rx_beat_i),
        .good_count_o (good_count),
        .err_count_o  (err_count),
        .comm_good_o  (comm_good_o)
    );

    // host readback
    reg_read_mux reg_read_mux_inst (
        .sysclk         (sysclk),
        .rst_n_i        (rst_n_i),
        .reg_raddr_i    (reg_raddr_i),
        .fields_i       (fields),
        .enc_i          (enc),
        .good_count_i   (good_count),
        .err_count_i    (err_count),
        .espm_rd_data_i (espm_rd_data),
        .reg_rdata_o    (reg_rdata_o)
    );

    assign esii_good_o    = fields.esii_word[1];
    assign is_ecm_o       = fields.esii_word[0];
    assign preload_good_o = fields.preload_valid;

endmodule

/* dv/espm_rx_tb.sv */
// testbench for the ESPM receive path: clock, LCG, frame driver, reference model, checks
`timescale 1ns/1ns

module espm_rx_tb;

    localparam int WDOG        = 256;
    localparam int COMMIT_WAIT = 70;  // commit latency bound

    logic                sysclk;
    logic                rst_n_i;
    espm_pkg::rx_beat_t  rx_beat;
    espm_pkg::reg_wr_t   reg_wr;
    espm_pkg::reg_addr_u reg_raddr;
    logic [31:0]         reg_rdata;
    logic                comm_good;
    logic                esii_good;
    logic                is_ecm;
    logic                preload_good;

    // reference state
    logic [31:0] exp_frame   [64];  // last good frame
    logic [31:0] new_frame   [64];
    logic [23:0] exp_preload [1:7];
    logic [23:0] exp_off     [1:7];
    logic        exp_ovf     [1:7];
    logic [31:0] exp_good;
    logic [31:0] exp_err;

    logic [31:0] rand_state;
    int          checks;
    int          errors;
    logic        rd_issue;
    logic        cmp_valid;
    logic [15:0] cmp_addr;
    logic [15:0] addr_q [$];

    espm_rx_top #(
        .WDOG_CYCLES (WDOG)
    ) espm_rx_top_inst (
        .sysclk         (sysclk),
        .rst_n_i        (rst_n_i),
        .rx_beat_i      (rx_beat),
        .reg_wr_i       (reg_wr),
        .reg_raddr_i    (reg_raddr),
        .reg_rdata_o    (reg_rdata),
        .comm_good_o    (comm_good),
        .esii_good_o    (esii_good),
        .is_ecm_o       (is_ecm),
        .preload_good_o (preload_good)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;
    end

    // --------------------------------------------------------------------------
    // reference model
    // --------------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [23:0] pos_of(int c);
        return exp_frame[int'(espm_pkg::ROW_POS) * 8 + c][23:0];
    endfunction

    function automatic logic [11:0] pot_of(int c);
        return exp_frame[int'(espm_pkg::ROW_POT) * 8 + c][17:6];
    endfunction

    function automatic logic is_preload_write(espm_pkg::reg_wr_t w);
        logic [15:0] a;
        a = w.waddr;
        return w.wen && (a[15:12] == espm_pkg::ADDR_MAIN) && (a[3:0] == espm_pkg::OFF_ENC_LOAD)
            && (a[7:4] >= 4'd1) && (a[7:4] <= 4'd7);
    endfunction

    function automatic logic [31:0] ref_read(logic [15:0] a);
        logic [3:0]  chan;
        logic        chan_ok;
        logic [31:0] r;
        chan    = a[7:4];
        chan_ok = (chan >= 4'd1) && (chan <= 4'd7);
        r       = espm_pkg::READ_FILL;
        if (a[15:12] == espm_pkg::ADDR_MAIN) begin
            if (a[3:0] == espm_pkg::OFF_ADC_DATA) begin
                r = chan_ok ? {4'h0, pot_of(chan), 16'h0} : {espm_pkg::POT_FILL, 16'h0};
            end else if (a[3:0] == espm_pkg::OFF_ENC_LOAD && chan_ok) begin
                r = {8'h0, exp_preload[chan]};
            end else if (a[3:0] == espm_pkg::OFF_ENC_DATA && chan_ok) begin
                r = {7'h0, exp_ovf[chan], pos_of(chan) + exp_off[chan]};
            end
        end else if (a[15:12] == espm_pkg::ADDR_BOARD_SPECIFIC) begin
            case (a[11:0])
                espm_pkg::BS_CRC_ERR:    r = exp_err;
                espm_pkg::BS_CRC_GOOD:   r = exp_good;
                espm_pkg::BS_ESII:       r = exp_frame[espm_pkg::W_ESII];
                espm_pkg::BS_INST_MODEL: r = exp_frame[espm_pkg::W_INST_MODEL];
                espm_pkg::BS_INST_ID:    r = exp_frame[espm_pkg::W_INST_ID];
                espm_pkg::BS_SWITCH:     r = exp_frame[espm_pkg::W_SWITCH];
                espm_pkg::BS_BUILD:      r = espm_pkg::BUILD_NUMBER;
                default:                 r = espm_pkg::READ_FILL;
            endcase
        end else if (a[15:12] == espm_pkg::ADDR_ESPM) begin
            r = exp_frame[a[5:0]];
        end
        return r;
    endfunction

    task automatic compare_val(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        $display("Timeout at %0t ns: %s never reached the expected state", $time, what);
    endtask

    // read pipeline, address sampled on the edge the DUT takes it
    always @(posedge sysclk) begin
        cmp_valid <= rd_issue;
        cmp_addr  <= reg_raddr;
    end

    // compare first, then advance the overflow model to the next edge
    always @(negedge sysclk) begin : ref_track
        logic [23:0] p;
        if (cmp_valid === 1'b1) begin
            compare_val($sformatf("reg_rdata_o[%h]", cmp_addr), reg_rdata, ref_read(cmp_addr));
        end
        if (rst_n_i !== 1'b1) begin
            for (int c = 1; c <= 7; c++) exp_ovf[c] = 1'b0;
        end else if (!is_preload_write(reg_wr)) begin
            for (int c = 1; c <= 7; c++) begin
                p = pos_of(c) + exp_off[c];
                if (p[23:12] == 12'h000 || p[23:12] == 12'hFFF) exp_ovf[c] = 1'b1;
            end
        end
    end

    // --------------------------------------------------------------------------
    // stimulus tasks
    // --------------------------------------------------------------------------
    task automatic send_frame(input logic good);
        for (int i = 0; i < 64; i++) new_frame[i] = lcg_next();
        for (int i = 0; i < 64; i++) begin
            @(posedge sysclk);
            rx_beat <= {1'b1, 6'(i), new_frame[i], (i == 63), good && (i == 63)};
        end
        @(posedge sysclk);
        rx_beat <= '0;
        repeat (COMMIT_WAIT) @(posedge sysclk);
        if (good) begin
            exp_frame = new_frame;
            exp_good++;
        end else begin
            exp_err++;  // eof without crc_good
        end
    endtask

    task automatic write_preloads();
        logic [31:0] v;
        for (int c = 1; c <= 7; c++) begin
            v = lcg_next();
            // channels 1 and 2 land in the overflow band
            if (c == 1) v[23:12] = 12'h000;
            if (c == 2) v[23:12] = 12'hFFF;
            @(posedge sysclk);
            reg_wr <= {1'b1, espm_pkg::ADDR_MAIN, 4'h0, 4'(c), espm_pkg::OFF_ENC_LOAD, v};
            exp_preload[c] = v[23:0];
            exp_off[c]     = v[23:0] - pos_of(c);
            exp_ovf[c]     = 1'b0;
        end
        @(posedge sysclk);
        reg_wr <= '0;
    endtask

    // issue every queued address back to back, then let the compares drain
    task automatic run_reads();
        logic [15:0] a;
        int          n;
        while (addr_q.size() > 0) begin
            a = addr_q.pop_front();
            @(posedge sysclk);
            reg_raddr <= a;
            rd_issue  <= 1'b1;
        end
        @(posedge sysclk);
        rd_issue <= 1'b0;
        n = 0;
        do begin
            @(posedge sysclk);
            n++;
        end while (cmp_valid !== 1'b0 && n < 8);
        if (cmp_valid !== 1'b0) note_timeout("read pipeline");
    endtask

    task automatic wait_comm(input logic level, input int limit);
        int n;
        n = 0;
        while (comm_good !== level && n < limit) begin
            @(posedge sysclk);
            n++;
        end
        if (comm_good !== level) note_timeout("comm_good_o");
    endtask

    function automatic logic [15:0] main_addr(logic [3:0] chan, logic [3:0] off);
        return {espm_pkg::ADDR_MAIN, 4'h0, chan, off};
    endfunction

    function automatic logic [15:0] rand_addr();
        logic [31:0] r;
        logic [11:0] boff;
        r = lcg_next();
        case (r[1:0])
            2'd0: return {espm_pkg::ADDR_MAIN, r[15:12], r[11:8], 1'b0, r[6:4]};
            2'd1: begin
                case (r[4:2])
                    3'd0:    boff = espm_pkg::BS_CRC_ERR;
                    3'd1:    boff = espm_pkg::BS_CRC_GOOD;
                    3'd2:    boff = espm_pkg::BS_ESII;
                    3'd3:    boff = espm_pkg::BS_INST_MODEL;
                    3'd4:    boff = espm_pkg::BS_INST_ID;
                    3'd5:    boff = espm_pkg::BS_SWITCH;
                    3'd6:    boff = espm_pkg::BS_BUILD;
                    default: boff = r[27:16];  // mostly unmapped
                endcase
                return {espm_pkg::ADDR_BOARD_SPECIFIC, boff};
            end
            2'd2:    return {espm_pkg::ADDR_ESPM, r[21:10]};
            default: return r[31:16];
        endcase
    endfunction

    task automatic queue_frame_reads();
        for (int i = 0; i < 64; i++) addr_q.push_back({espm_pkg::ADDR_ESPM, 12'(i)});
        for (int c = 0; c <= 8; c++) addr_q.push_back(main_addr(4'(c), espm_pkg::OFF_ADC_DATA));
        for (int i = 0; i < 7; i++) begin
            addr_q.push_back({espm_pkg::ADDR_BOARD_SPECIFIC, board_offset(i)});
        end
    endtask

    function automatic logic [11:0] board_offset(int i);
        logic [11:0] offs [7];
        offs = '{espm_pkg::BS_CRC_ERR, espm_pkg::BS_CRC_GOOD, espm_pkg::BS_ESII,
                 espm_pkg::BS_INST_MODEL, espm_pkg::BS_INST_ID, espm_pkg::BS_SWITCH,
                 espm_pkg::BS_BUILD};
        return offs[i];
    endfunction

    task automatic check_status();
        compare_val("esii_good_o", {31'h0, esii_good}, {31'h0, exp_frame[espm_pkg::W_ESII][1]});
        compare_val("is_ecm_o", {31'h0, is_ecm}, {31'h0, exp_frame[espm_pkg::W_ESII][0]});
        compare_val("preload_good_o", {31'h0, preload_good},
                    {31'h0, exp_frame[espm_pkg::W_PRELOAD_VALID][0]});
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - err_before);
    endtask

    // --------------------------------------------------------------------------
    // test sequence
    // --------------------------------------------------------------------------
    initial begin
        int e0;
        rand_state = 32'ha6fc;
        rst_n_i    = 1'b0;
        rx_beat    = '0;
        reg_wr     = '0;
        reg_raddr  = '0;
        rd_issue   = 1'b0;
        cmp_valid  = 1'b0;
        checks     = 0;
        errors     = 0;
        exp_good   = '0;
        exp_err    = '0;
        for (int i = 0; i < 64; i++) exp_frame[i] = '0;
        for (int c = 1; c <= 7; c++) begin
            exp_preload[c] = espm_pkg::ENC_MIDRANGE;
            exp_off[c]     = '0;
            exp_ovf[c]     = 1'b0;
        end
        repeat (16) @(posedge sysclk);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge sysclk);

        e0 = errors;
        compare_val("comm_good_o", {31'h0, comm_good}, 32'h0);
        check_status();  // reset fields are all zero
        addr_q.push_back({espm_pkg::ADDR_BOARD_SPECIFIC, espm_pkg::BS_CRC_ERR});
        addr_q.push_back({espm_pkg::ADDR_BOARD_SPECIFIC, espm_pkg::BS_CRC_GOOD});
        addr_q.push_back({espm_pkg::ADDR_BOARD_SPECIFIC, espm_pkg::BS_BUILD});
        addr_q.push_back(16'h1234);
        for (int c = 1; c <= 7; c++) addr_q.push_back(main_addr(4'(c), espm_pkg::OFF_ENC_LOAD));
        run_reads();
        end_test("reset state", e0);

        e0 = errors;
        send_frame(1'b1);
        check_status();
        queue_frame_reads();
        run_reads();
        send_frame(1'b0);  // bad crc, nothing committed
        check_status();
        queue_frame_reads();
        run_reads();
        end_test("frame commit and decode", e0);

        e0 = errors;
        write_preloads();
        for (int c = 0; c <= 8; c++) begin
            addr_q.push_back(main_addr(4'(c), espm_pkg::OFF_ENC_LOAD));
            addr_q.push_back(main_addr(4'(c), espm_pkg::OFF_ENC_DATA));
        end
        run_reads();
        send_frame(1'b1);
        for (int c = 0; c <= 8; c++) addr_q.push_back(main_addr(4'(c), espm_pkg::OFF_ENC_DATA));
        run_reads();
        end_test("encoder preload", e0);

        e0 = errors;
        repeat (5) send_frame(1'b1);  // one frame about every 136 cycles
        compare_val("comm_good_o", {31'h0, comm_good}, 32'h1);
        wait_comm(1'b0, 3 * WDOG);
        compare_val("comm_good_o", {31'h0, comm_good}, 32'h0);
        addr_q.push_back({espm_pkg::ADDR_BOARD_SPECIFIC, espm_pkg::BS_CRC_GOOD});
        run_reads();
        end_test("link watchdog", e0);

        e0 = errors;
        repeat (200) addr_q.push_back(rand_addr());
        run_reads();
        end_test("back-to-back reads", e0);

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* espm_rx_top.f */
src/espm_pkg.sv
src/frame_store.sv
src/field_decode.sv
src/encoder_preload.sv
src/link_monitor.sv
src/reg_read_mux.sv
src/espm_rx_top.sv
dv/espm_rx_tb.sv

/* Bender.yml */
package:
  name: espm_rx

sources:
  - files:
      - src/espm_pkg.sv
      - src/frame_store.sv
      - src/field_decode.sv
      - src/encoder_preload.sv
      - src/link_monitor.sv
      - src/reg_read_mux.sv
      - src/espm_rx_top.sv
  - target: test
    files:
      - dv/espm_rx_tb.sv
